//--- source/cellbuf_pkg.sv
`default_nettype none

package cellbuf_pkg;

    // Geometry
    localparam int PIXEL_W   = 8;
    localparam int CELL_PX   = 4;
    localparam int CELL_COLS = 8;
    localparam int WIN_WORDS = 8;
    localparam int ADDR_W    = 12;

    localparam int CELL_ROW_W = PIXEL_W * CELL_PX;
    localparam int COL_W      = $clog2(CELL_COLS);
    localparam int ROW_IDX_W  = $clog2(CELL_PX);
    localparam int SLOT_W     = $clog2(WIN_WORDS);

    // Byte offset bits of a 32-bit APB word
    localparam int WORD_LSB = 2;

    typedef logic [PIXEL_W-1:0]            pixel_t;
    typedef logic [CELL_ROW_W-1:0]         cell_row_t;
    typedef logic [CELL_PX*CELL_ROW_W-1:0] cell_rows_t;
    typedef logic [COL_W-1:0]              cell_col_t;
    typedef logic [ROW_IDX_W-1:0]          cell_row_idx_t;
    typedef logic [SLOT_W-1:0]             win_slot_t;
    typedef logic [ADDR_W-1:0]             apb_addr_t;

    // Address map
    localparam apb_addr_t PIX_BASE  = 12'h000;
    localparam apb_addr_t WIN_BASE  = 12'h100;
    localparam apb_addr_t CTRL_ADDR = 12'h200;

    localparam apb_addr_t PIX_SPAN = apb_addr_t'((CELL_COLS * CELL_PX) << WORD_LSB);
    localparam apb_addr_t WIN_SPAN = apb_addr_t'((CELL_COLS * WIN_WORDS) << WORD_LSB);

    // Line control bits
    localparam int CTRL_ADVANCE = 0;
    localparam int CTRL_CLEAR   = 1;

    // Window slots above the interior rows
    localparam win_slot_t SLOT_TOP   = 3'd4;
    localparam win_slot_t SLOT_LEFT  = 3'd5;
    localparam win_slot_t SLOT_RIGHT = 3'd6;
    localparam win_slot_t SLOT_ZERO  = 3'd7;

    typedef enum logic [1:0] {
        PORT_IDLE,
        PORT_READ_WAIT,
        PORT_RESP
    } port_state_e;

endpackage

`default_nettype wire

//--- source/apb_cell_port.sv
`timescale 1ns/1ps
`default_nettype none

module apb_cell_port
    import cellbuf_pkg::*;
(
    input  logic          clk,
    input  logic          rst_i,
    input  logic          psel_i,
    input  logic          penable_i,
    input  logic          pwrite_i,
    input  apb_addr_t     paddr_i,
    input  cell_row_t     pwdata_i,
    input  cell_row_t     win_word_i,
    output cell_row_t     prdata_o,
    output logic          pready_o,
    output logic          pslverr_o,
    output logic          wr_en_o,
    output cell_col_t     wr_col_o,
    output cell_row_idx_t wr_row_o,
    output cell_row_t     wr_data_o,
    output logic          line_advance_o,
    output logic          line_clear_o,
    output logic          rd_en_o,
    output cell_col_t     rd_col_o,
    output win_slot_t     rd_slot_o
);

    port_state_e state_q;
    logic        accept;
    apb_addr_t   pix_off;
    apb_addr_t   win_off;
    logic        hit_pix;
    logic        hit_win;
    logic        hit_ctrl;
    logic        wr_pix;
    logic        rd_win;
    logic        wr_ctrl;
    logic        req_err;
    logic        pready_q;
    logic        pslverr_q;
    logic        rd_data_q;

    // Setup cycle of a new transfer
    assign accept = psel_i && !penable_i && (state_q == PORT_IDLE);

    // Unsigned offsets wrap, so one compare checks both bounds
    assign pix_off  = paddr_i - PIX_BASE;
    assign win_off  = paddr_i - WIN_BASE;
    assign hit_pix  = pix_off < PIX_SPAN;
    assign hit_win  = win_off < WIN_SPAN;
    assign hit_ctrl = paddr_i[ADDR_W-1:WORD_LSB] == CTRL_ADDR[ADDR_W-1:WORD_LSB];

    assign wr_pix  = hit_pix && pwrite_i;
    assign rd_win  = hit_win && !pwrite_i;
    assign wr_ctrl = hit_ctrl && pwrite_i;
    assign req_err = !(wr_pix || rd_win || wr_ctrl);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q        <= PORT_IDLE;
            pready_q       <= 1'b0;
            pslverr_q      <= 1'b0;
            rd_data_q      <= 1'b0;
            wr_en_o        <= 1'b0;
            line_advance_o <= 1'b0;
            line_clear_o   <= 1'b0;
            rd_en_o        <= 1'b0;
        end else begin
            // Commands last one cycle
            wr_en_o        <= 1'b0;
            line_advance_o <= 1'b0;
            line_clear_o   <= 1'b0;
            rd_en_o        <= 1'b0;
            case (state_q)
                PORT_IDLE: begin
                    if (accept) begin
                        wr_en_o        <= wr_pix;
                        line_advance_o <= wr_ctrl && pwdata_i[CTRL_ADVANCE]
                                          && !pwdata_i[CTRL_CLEAR];
                        line_clear_o   <= wr_ctrl && pwdata_i[CTRL_CLEAR];
                        rd_en_o        <= rd_win;
                        rd_data_q      <= rd_win;
                        pslverr_q      <= req_err;
                        if (rd_win) begin
                            state_q <= PORT_READ_WAIT;
                        end else begin
                            pready_q <= 1'b1;
                            state_q  <= PORT_RESP;
                        end
                    end
                end
                PORT_READ_WAIT: begin
                    pready_q <= 1'b1;
                    state_q  <= PORT_RESP;
                end
                PORT_RESP: begin
                    pready_q  <= 1'b0;
                    pslverr_q <= 1'b0;
                    rd_data_q <= 1'b0;
                    state_q   <= PORT_IDLE;
                end
                default: state_q <= PORT_IDLE;
            endcase
        end
    end

    // Request fields, held until the response
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_col_o  <= pix_off[WORD_LSB+ROW_IDX_W +: COL_W];
            wr_row_o  <= pix_off[WORD_LSB +: ROW_IDX_W];
            wr_data_o <= pwdata_i;
            rd_col_o  <= win_off[WORD_LSB+SLOT_W +: COL_W];
            rd_slot_o <= win_off[WORD_LSB +: SLOT_W];
        end
    end

    assign pready_o  = pready_q;
    assign pslverr_o = pslverr_q;
    assign prdata_o  = (rd_data_q && pready_q) ? win_word_i : '0;

    a_setup_before_access: assert property (@(posedge clk) disable iff (rst_i)
        $rose(penable_i) |-> $past(psel_i && !penable_i));

    a_ready_in_access: assert property (@(posedge clk) disable iff (rst_i)
        pready_o |-> psel_i && penable_i);

endmodule

`default_nettype wire

//--- source/cell_store.sv
`timescale 1ns/1ps
`default_nettype none

module cell_store
    import cellbuf_pkg::*;
(
    input  logic          clk,
    input  logic          rst_i,
    input  logic          wr_en_i,
    input  cell_col_t     wr_col_i,
    input  cell_row_idx_t wr_row_i,
    input  cell_row_t     wr_data_i,
    input  logic          line_advance_i,
    input  logic          line_clear_i,
    input  logic          rd_en_i,
    input  cell_col_t     rd_col_i,
    output cell_rows_t    center_rows_o,
    output cell_rows_t    left_rows_o,
    output cell_rows_t    right_rows_o,
    output cell_row_t     top_row_o
);

    // Four pixel rows per cell, row r in word r
    cell_rows_t pix_q [CELL_COLS];

    // Last row of each cell from the previous line
    cell_row_t  top_q [CELL_COLS];

    cell_col_t  left_col;
    cell_col_t  right_col;

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            pix_q[wr_col_i][wr_row_i*CELL_ROW_W +: CELL_ROW_W] <= wr_data_i;
        end
    end

    // Clear has priority over advance
    always_ff @(posedge clk) begin
        if (rst_i || line_clear_i) begin
            for (int c = 0; c < CELL_COLS; c++) begin
                top_q[c] <= '0;
            end
        end else if (line_advance_i) begin
            for (int c = 0; c < CELL_COLS; c++) begin
                top_q[c] <= pix_q[c][(CELL_PX-1)*CELL_ROW_W +: CELL_ROW_W];
            end
        end
    end

    // Neighbours wrap at the line ends
    assign left_col  = rd_col_i - cell_col_t'(1);
    assign right_col = rd_col_i + cell_col_t'(1);

    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            center_rows_o <= pix_q[rd_col_i];
            left_rows_o   <= pix_q[left_col];
            right_rows_o  <= pix_q[right_col];
            top_row_o     <= top_q[rd_col_i];
        end
    end

    // The port sends one command per transfer
    a_no_write_on_advance: assert property (@(posedge clk) disable iff (rst_i)
        !(wr_en_i && line_advance_i));

endmodule

`default_nettype wire

//--- source/halo_window.sv
`timescale 1ns/1ps
`default_nettype none

module halo_window
    import cellbuf_pkg::*;
(
    input  cell_col_t  rd_col_i,
    input  win_slot_t  rd_slot_i,
    input  cell_rows_t center_rows_i,
    input  cell_rows_t left_rows_i,
    input  cell_rows_t right_rows_i,
    input  cell_row_t  top_row_i,
    output cell_row_t  win_word_o
);

    cell_row_t     left_col;
    cell_row_t     right_col;
    cell_row_t     inner_word;
    cell_row_idx_t inner_row;
    logic          first_col;
    logic          last_col;

    // One pixel per row of a neighbour, row r lands in byte r
    function automatic cell_row_t gather_column(input cell_rows_t rows, input int px);
        cell_row_t col;
        pixel_t    pix;
        col = '0;
        for (int r = 0; r < CELL_PX; r++) begin
            pix = rows[r*CELL_ROW_W + px*PIXEL_W +: PIXEL_W];
            col[r*PIXEL_W +: PIXEL_W] = pix;
        end
        return col;
    endfunction

    assign left_col  = gather_column(left_rows_i, CELL_PX - 1);
    assign right_col = gather_column(right_rows_i, 0);

    // Frame edges have no neighbour
    assign first_col = rd_col_i == '0;
    assign last_col  = rd_col_i == cell_col_t'(CELL_COLS - 1);

    assign inner_row  = rd_slot_i[ROW_IDX_W-1:0];
    assign inner_word = center_rows_i[inner_row*CELL_ROW_W +: CELL_ROW_W];

    always_comb begin
        win_word_o = '0;
        case (rd_slot_i)
            SLOT_TOP: begin
                win_word_o = top_row_i;
            end
            SLOT_LEFT: begin
                win_word_o = first_col ? '0 : left_col;
            end
            SLOT_RIGHT: begin
                win_word_o = last_col ? '0 : right_col;
            end
            SLOT_ZERO: begin
                win_word_o = '0;
            end
            // Slots 0 to 3 are the cell's own rows
            default: begin
                win_word_o = inner_word;
            end
        endcase
    end

    // Column and slot are latched together by the port
    always_comb begin
        if (!$isunknown(rd_col_i)) begin
            a_slot_known: assert final (!$isunknown(rd_slot_i));
        end
    end

endmodule

`default_nettype wire

//--- source/cell_buffer_top.sv
`timescale 1ns/1ps
`default_nettype none

module cell_buffer_top
    import cellbuf_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  cell_row_t pwdata_i,
    output cell_row_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o
);

    logic          wr_en;
    cell_col_t     wr_col;
    cell_row_idx_t wr_row;
    cell_row_t     wr_data;
    logic          line_advance;
    logic          line_clear;
    logic          rd_en;
    cell_col_t     rd_col;
    win_slot_t     rd_slot;
    cell_rows_t    center_rows;
    cell_rows_t    left_rows;
    cell_rows_t    right_rows;
    cell_row_t     top_row;
    cell_row_t     win_word;

    apb_cell_port port_i (
        .clk            (clk),
        .rst_i          (rst_i),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .paddr_i        (paddr_i),
        .pwdata_i       (pwdata_i),
        .win_word_i     (win_word),
        .prdata_o       (prdata_o),
        .pready_o       (pready_o),
        .pslverr_o      (pslverr_o),
        .wr_en_o        (wr_en),
        .wr_col_o       (wr_col),
        .wr_row_o       (wr_row),
        .wr_data_o      (wr_data),
        .line_advance_o (line_advance),
        .line_clear_o   (line_clear),
        .rd_en_o        (rd_en),
        .rd_col_o       (rd_col),
        .rd_slot_o      (rd_slot)
    );

    cell_store store_i (
        .clk            (clk),
        .rst_i          (rst_i),
        .wr_en_i        (wr_en),
        .wr_col_i       (wr_col),
        .wr_row_i       (wr_row),
        .wr_data_i      (wr_data),
        .line_advance_i (line_advance),
        .line_clear_i   (line_clear),
        .rd_en_i        (rd_en),
        .rd_col_i       (rd_col),
        .center_rows_o  (center_rows),
        .left_rows_o    (left_rows),
        .right_rows_o   (right_rows),
        .top_row_o      (top_row)
    );

    halo_window window_i (
        .rd_col_i      (rd_col),
        .rd_slot_i     (rd_slot),
        .center_rows_i (center_rows),
        .left_rows_i   (left_rows),
        .right_rows_i  (right_rows),
        .top_row_i     (top_row),
        .win_word_o    (win_word)
    );

endmodule

`default_nettype wire

//--- testbench/cell_buffer_tests.svh
`ifndef CELL_BUFFER_TESTS_SVH
`define CELL_BUFFER_TESTS_SVH

task automatic test_interior_rw();
    int        errors_before;
    cell_row_t data;
    errors_before = error_count;
    for (int c = 0; c < CELL_COLS; c++) begin
        for (int r = 0; r < CELL_PX; r++) begin
            data = lcg_next();
            write_checked(pix_addr(c, r), data);
            model_rows[c][r] = data;
        end
    end
    check_window_slots(0, CELL_PX - 1);
    finish_test("interior_rw", errors_before);
endtask

// Left, right and the unused slot
task automatic test_side_halos();
    int errors_before;
    errors_before = error_count;
    check_window_slots(5, 7);
    finish_test("side_halos", errors_before);
endtask

task automatic test_top_halo();
    int        errors_before;
    cell_row_t data;
    errors_before = error_count;
    // No line command yet, so halos hold their reset value
    check_window_slots(4, 4);
    write_checked(CTRL_ADDR, 32'h1);
    for (int c = 0; c < CELL_COLS; c++) begin
        model_top[c] = model_rows[c][3];
    end
    check_window_slots(4, 4);
    // New last rows must not leak into the halo
    for (int c = 0; c < CELL_COLS; c++) begin
        data = lcg_next();
        write_checked(pix_addr(c, 3), data);
        model_rows[c][3] = data;
    end
    check_window_slots(3, 4);
    write_checked(CTRL_ADDR, 32'h2);
    for (int c = 0; c < CELL_COLS; c++) begin
        model_top[c] = '0;
    end
    check_window_slots(4, 4);
    write_checked(CTRL_ADDR, 32'h1);
    for (int c = 0; c < CELL_COLS; c++) begin
        model_top[c] = model_rows[c][3];
    end
    check_window_slots(4, 4);
    // Clear wins over advance
    write_checked(CTRL_ADDR, 32'h3);
    for (int c = 0; c < CELL_COLS; c++) begin
        model_top[c] = '0;
    end
    check_window_slots(4, 4);
    finish_test("top_halo", errors_before);
endtask

task automatic test_error_responses();
    int        errors_before;
    cell_row_t data;
    logic      err;
    int        waits;
    apb_addr_t bad_writes [4];
    apb_addr_t bad_reads [4];
    errors_before = error_count;
    // Nonzero halos so that a stray clear would show
    write_checked(CTRL_ADDR, 32'h1);
    for (int c = 0; c < CELL_COLS; c++) begin
        model_top[c] = model_rows[c][3];
    end
    bad_writes = '{12'h080, 12'h204, 12'h300, WIN_BASE + 12'h004};
    bad_reads  = '{12'h080, 12'h3fc, pix_addr(2, 1), CTRL_ADDR};
    for (int i = 0; i < 4; i++) begin
        apb_transfer(1'b1, bad_writes[i], 32'h2, data, err, waits);
        if (err !== 1'b1) begin
            report_mismatch($sformatf("pslverr_o write %h", bad_writes[i]), 32'd1, err);
        end
        if (data !== '0) begin
            report_mismatch("prdata_o", 32'd0, data);
        end
        apb_read(bad_reads[i], data, err, waits);
        if (err !== 1'b1) begin
            report_mismatch($sformatf("pslverr_o read %h", bad_reads[i]), 32'd1, err);
        end
        if (data !== '0) begin
            report_mismatch("prdata_o", 32'd0, data);
        end
    end
    check_window_slots(0, 6);
    finish_test("error_responses", errors_before);
endtask

task automatic test_response_timing();
    int        errors_before;
    cell_row_t data;
    logic      err;
    int        waits;
    errors_before = error_count;
    data = lcg_next();
    apb_write(pix_addr(5, 2), data, err, waits);
    model_rows[5][2] = data;
    if (waits != 0) begin
        report_mismatch("write wait cycles", 32'd0, waits);
    end
    if (err !== 1'b0) begin
        report_mismatch("pslverr_o", 32'd0, err);
    end
    apb_write(CTRL_ADDR, 32'h0, err, waits);
    if (waits != 0) begin
        report_mismatch("control write wait cycles", 32'd0, waits);
    end
    if (err !== 1'b0) begin
        report_mismatch("pslverr_o", 32'd0, err);
    end
    apb_read(win_addr(6, 5), data, err, waits);
    if (waits != 1) begin
        report_mismatch("read wait cycles", 32'd1, waits);
    end
    if (err !== 1'b0) begin
        report_mismatch("pslverr_o", 32'd0, err);
    end
    if (data !== expected_window(6, 5)) begin
        report_mismatch("prdata_o", expected_window(6, 5), data);
    end
    apb_read(CTRL_ADDR, data, err, waits);
    if (waits != 0) begin
        report_mismatch("error wait cycles", 32'd0, waits);
    end
    if (err !== 1'b1) begin
        report_mismatch("pslverr_o", 32'd1, err);
    end
    finish_test("response_timing", errors_before);
endtask

`endif

//--- testbench/tb_cell_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cell_buffer
    import cellbuf_pkg::*;
();

    localparam int MAX_WAIT = 16;

    logic      clk;
    logic      rst_i;
    logic      psel_i;
    logic      penable_i;
    logic      pwrite_i;
    apb_addr_t paddr_i;
    cell_row_t pwdata_i;
    cell_row_t prdata_o;
    logic      pready_o;
    logic      pslverr_o;

    // Reference copy of the cell rows and top halos
    cell_row_t model_rows [CELL_COLS][CELL_PX];
    cell_row_t model_top [CELL_COLS];

    int unsigned lcg_state;
    int          error_count;
    int          pass_count;
    int          fail_count;

    cell_buffer_top dut_i (
        .clk       (clk),
        .rst_i     (rst_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o)
    );

    always #50 clk = ~clk;

    function automatic cell_row_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic apb_addr_t pix_addr(input int col, input int row);
        return PIX_BASE + apb_addr_t'((col * CELL_PX + row) * 4);
    endfunction

    function automatic apb_addr_t win_addr(input int col, input int slot);
        return WIN_BASE + apb_addr_t'((col * WIN_WORDS + slot) * 4);
    endfunction

    // Window word as software expects it
    function automatic cell_row_t expected_window(input int col, input int slot);
        cell_row_t word;
        word = '0;
        for (int r = 0; r < CELL_PX; r++) begin
            if (slot == 5 && col > 0) begin
                word[r*8 +: 8] = model_rows[col-1][r][31:24];
            end
            if (slot == 6 && col < CELL_COLS - 1) begin
                word[r*8 +: 8] = model_rows[col+1][r][7:0];
            end
        end
        if (slot < CELL_PX) begin
            word = model_rows[col][slot];
        end else if (slot == 4) begin
            word = model_top[col];
        end
        return word;
    endfunction

    task automatic report_mismatch(input string name, input cell_row_t expected,
                                   input cell_row_t actual);
        $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        error_count++;
    endtask

    task automatic report_timeout(input apb_addr_t addr);
        $display("No pready within %0d cycles for address %h at %0t ns", MAX_WAIT, addr, $time);
        $display("tests failed");
        $finish;
    endtask

    task automatic apb_transfer(input logic write, input apb_addr_t addr, input cell_row_t wdata,
                                output cell_row_t rdata, output logic err, output int waits);
        @(posedge clk);
        #1;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = write;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(posedge clk);
        #1;
        penable_i = 1'b1;
        waits = 0;
        while (!pready_o && waits < MAX_WAIT) begin
            @(posedge clk);
            #1;
            waits++;
        end
        if (!pready_o) begin
            report_timeout(addr);
        end
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk);
        #1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input cell_row_t data,
                             output logic err, output int waits);
        cell_row_t rdata_ignored;
        apb_transfer(1'b1, addr, data, rdata_ignored, err, waits);
    endtask

    task automatic apb_read(input apb_addr_t addr, output cell_row_t data,
                            output logic err, output int waits);
        apb_transfer(1'b0, addr, '0, data, err, waits);
    endtask

    task automatic write_checked(input apb_addr_t addr, input cell_row_t data);
        logic err;
        int   waits;
        apb_write(addr, data, err, waits);
        if (err !== 1'b0) begin
            report_mismatch("pslverr_o", 32'd0, err);
        end
    endtask

    // Read a range of slots of every cell against the model
    task automatic check_window_slots(input int first_slot, input int last_slot);
        cell_row_t data;
        logic      err;
        int        waits;
        for (int c = 0; c < CELL_COLS; c++) begin
            for (int s = first_slot; s <= last_slot; s++) begin
                apb_read(win_addr(c, s), data, err, waits);
                if (data !== expected_window(c, s)) begin
                    report_mismatch($sformatf("prdata_o col %0d slot %0d", c, s),
                                    expected_window(c, s), data);
                end
                if (err !== 1'b0) begin
                    report_mismatch("pslverr_o", 32'd0, err);
                end
            end
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("Test %s: ok", name);
            pass_count++;
        end else begin
            $display("Test %s: %0d mismatches", name, error_count - errors_before);
            fail_count++;
        end
    endtask

    `include "cell_buffer_tests.svh"

    initial begin
        clk         = 1'b0;
        rst_i       = 1'b1;
        psel_i      = 1'b0;
        penable_i   = 1'b0;
        pwrite_i    = 1'b0;
        paddr_i     = '0;
        pwdata_i    = '0;
        lcg_state   = 47290;
        error_count = 0;
        pass_count  = 0;
        fail_count  = 0;
        for (int c = 0; c < CELL_COLS; c++) begin
            model_top[c] = '0;
            for (int r = 0; r < CELL_PX; r++) begin
                model_rows[c][r] = '0;
            end
        end
        repeat (2) @(posedge clk);
        #1;
        rst_i = 1'b0;
        test_interior_rw();
        test_side_halos();
        test_top_halo();
        test_error_responses();
        test_response_timing();
        $display("Summary: %0d ok, %0d with mismatches, %0d errors",
                 pass_count, fail_count, error_count);
        if (fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+testbench
source/cellbuf_pkg.sv
source/apb_cell_port.sv
source/cell_store.sv
source/halo_window.sv
source/cell_buffer_top.sv
testbench/tb_cell_buffer.sv

//--- Bender.yml
package:
  name: cell_buffer

sources:
  - files:
      - source/cellbuf_pkg.sv
      - source/apb_cell_port.sv
      - source/cell_store.sv
      - source/halo_window.sv
      - source/cell_buffer_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_cell_buffer.sv
